// ==== flist.f ====
logic/a2_card_pkg.sv
logic/a2_phase_sync.sv
logic/a2_bus_timing.sv
logic/card_bus_arbiter.sv
logic/audio_mixer.sv
logic/scanline_dimmer.sv
logic/a2_card_core.sv
tests/tb_a2_card_core.sv

// ==== logic/a2_bus_timing.sv ====
// Derives phase level, 2 MHz and 14 MHz strobes and the system reset from the Apple clocks
`timescale 1ns/1ps
`default_nettype none

module a2_bus_timing (
    input  logic clk_logic_w,
    input  logic rst_n_i,
    input  logic a2_phi1_i,
    input  logic a2_7m_i,
    input  logic a2_reset_n_i,
    output logic phase_o,
    output logic clk_2m_stb_o,
    output logic clk_14m_stb_o,
    output logic system_reset_n_o
);

    logic phi1_rise_w;
    logic phi1_fall_w;
    logic clk_7m_rise_w;
    logic clk_7m_fall_w;
    logic [1:0] a2_reset_sync_r;

    a2_phase_sync u_phi1_sync (
        .clk_logic_w (clk_logic_w),
        .rst_n_i     (rst_n_i),
        .async_i     (a2_phi1_i),
        .level_o     (phase_o),
        .rise_o      (phi1_rise_w),
        .fall_o      (phi1_fall_w)
    );

    // Only the edges of the 7 MHz clock matter here
    a2_phase_sync u_7m_sync (
        .clk_logic_w (clk_logic_w),
        .rst_n_i     (rst_n_i),
        .async_i     (a2_7m_i),
        .level_o     (),
        .rise_o      (clk_7m_rise_w),
        .fall_o      (clk_7m_fall_w)
    );

    // Both phi1 edges make a 2 MHz tick
    assign clk_2m_stb_o  = phi1_rise_w | phi1_fall_w;
    assign clk_14m_stb_o = clk_7m_rise_w | clk_7m_fall_w;

    // Apple reset synchronizer, board reset asserts it at once
    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            a2_reset_sync_r <= 2'b00;
        end else begin
            a2_reset_sync_r <= {a2_reset_sync_r[0], a2_reset_n_i};
        end
    end

    assign system_reset_n_o = a2_reset_sync_r[1];

endmodule

`default_nettype wire

// ==== logic/a2_card_core.sv ====
// Top level of the card glue logic, joins bus timing, arbiter, audio mixer and dimmer
`timescale 1ns/1ps
`default_nettype none

module a2_card_core
    import a2_card_pkg::*;
#(
    parameter bit BUS_DATA_OUT_ENABLE = 1'b1,
    parameter bit IRQ_OUT_ENABLE      = 1'b1,
    parameter bit SPEAKER_ENABLE      = 1'b0,
    parameter bit SCANLINES_ENABLE    = 1'b0
) (
    input  logic         clk_logic_w,
    input  logic         rst_n_i,

    // Apple bus clocks and reset
    input  logic         a2_phi1_i,
    input  logic         a2_7m_i,
    input  logic         a2_reset_n_i,

    // Card responses and latched bus byte
    input  card_resp_t   card_resp_i [NUM_CARDS],
    input  bus_data_t    bus_data_i,

    // Audio sources
    input  sample_t      sprite_audio_i,
    input  sound_level_t sound_left_i,
    input  sound_level_t sound_right_i,
    input  logic         speaker_i,

    // Video
    input  rgb_pixel_t   pixel_i,
    input  logic         line_odd_i,

    // Bit 0 scanlines, bit 1 speaker, both active low
    input  logic [1:0]   dip_switches_n_i,

    output logic         phase_o,
    output logic         clk_2m_stb_o,
    output logic         clk_14m_stb_o,
    output logic         system_reset_n_o,
    output bus_drive_t   bus_drive_o,
    output stereo_t      audio_o,
    output rgb_pixel_t   pixel_o
);

    logic scanline_sw_w;
    logic speaker_sw_w;

    assign scanline_sw_w = ~dip_switches_n_i[0];
    assign speaker_sw_w  = ~dip_switches_n_i[1];

    a2_bus_timing u_bus_timing (
        .clk_logic_w      (clk_logic_w),
        .rst_n_i          (rst_n_i),
        .a2_phi1_i        (a2_phi1_i),
        .a2_7m_i          (a2_7m_i),
        .a2_reset_n_i     (a2_reset_n_i),
        .phase_o          (phase_o),
        .clk_2m_stb_o     (clk_2m_stb_o),
        .clk_14m_stb_o    (clk_14m_stb_o),
        .system_reset_n_o (system_reset_n_o)
    );

    card_bus_arbiter #(
        .BUS_DATA_OUT_ENABLE (BUS_DATA_OUT_ENABLE),
        .IRQ_OUT_ENABLE      (IRQ_OUT_ENABLE)
    ) u_arbiter (
        .clk_logic_w (clk_logic_w),
        .rst_n_i     (rst_n_i),
        .card_resp_i (card_resp_i),
        .bus_data_i  (bus_data_i),
        .bus_drive_o (bus_drive_o)
    );

    audio_mixer #(
        .SPEAKER_ENABLE (SPEAKER_ENABLE)
    ) u_mixer (
        .clk_logic_w    (clk_logic_w),
        .rst_n_i        (rst_n_i),
        .sprite_audio_i (sprite_audio_i),
        .sound_left_i   (sound_left_i),
        .sound_right_i  (sound_right_i),
        .speaker_i      (speaker_i),
        .speaker_sw_i   (speaker_sw_w),
        .audio_o        (audio_o)
    );

    scanline_dimmer #(
        .SCANLINES_ENABLE (SCANLINES_ENABLE)
    ) u_dimmer (
        .clk_logic_w   (clk_logic_w),
        .rst_n_i       (rst_n_i),
        .pixel_i       (pixel_i),
        .line_odd_i    (line_odd_i),
        .scanline_sw_i (scanline_sw_w),
        .pixel_o       (pixel_o)
    );

endmodule

`default_nettype wire

// ==== logic/a2_card_pkg.sv ====
// Shared card count, field widths and bus, audio and pixel structs for the card glue logic
`default_nettype none

package a2_card_pkg;

    // Slot cards taking part in bus arbitration
    localparam int NUM_CARDS = 4;

    // Card order, index 0 wins the bus
    localparam int CARD_SERIAL = 0;
    localparam int CARD_SPRITE = 1;
    localparam int CARD_SOUND  = 2;
    localparam int CARD_DISK   = 3;

    // Audio weighting
    localparam int SOUND_SHIFT   = 5;
    localparam int SPEAKER_SHIFT = 13;

    typedef logic [7:0] bus_data_t;

    // One card's answer to the current bus cycle
    typedef struct packed {
        logic      rd_en;
        logic      irq_n;
        bus_data_t data;
    } card_resp_t;

    // What the card drives onto the Apple bus
    typedef struct packed {
        logic      oe;
        logic      irq_n;
        bus_data_t data;
    } bus_drive_t;

    typedef logic [15:0] sample_t;
    typedef logic [9:0]  sound_level_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_t;

    typedef struct packed {
        logic       active;
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_pixel_t;

endpackage

`default_nettype wire

// ==== logic/a2_phase_sync.sv ====
// Brings one Apple clock into the logic clock domain and flags its rising and falling edges
`timescale 1ns/1ps
`default_nettype none

module a2_phase_sync (
    input  logic clk_logic_w,
    input  logic rst_n_i,
    input  logic async_i,
    output logic level_o,
    output logic rise_o,
    output logic fall_o
);

    logic meta_r;
    logic sync_r;
    logic prev_r;

    // Two-flop synchronizer, first flop may go metastable
    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            meta_r <= 1'b0;
            sync_r <= 1'b0;
        end else begin
            meta_r <= async_i;
            sync_r <= meta_r;
        end
    end

    // History flop for edge detection
    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prev_r <= 1'b0;
        end else begin
            prev_r <= sync_r;
        end
    end

    assign level_o = sync_r;

    // Strobes last the one cycle where the new level first shows
    assign rise_o = sync_r & ~prev_r;
    assign fall_o = ~sync_r & prev_r;

endmodule

`default_nettype wire

// ==== logic/audio_mixer.sv ====
// Mixes sprite audio, sound card levels and the speaker bit into one stereo sample
`timescale 1ns/1ps
`default_nettype none

module audio_mixer
    import a2_card_pkg::*;
#(
    parameter bit SPEAKER_ENABLE = 1'b0
) (
    input  logic         clk_logic_w,
    input  logic         rst_n_i,
    input  sample_t      sprite_audio_i,
    input  sound_level_t sound_left_i,
    input  sound_level_t sound_right_i,
    input  logic         speaker_i,
    input  logic         speaker_sw_i,
    output stereo_t      audio_o
);

    logic    speaker_on_w;
    stereo_t mix_w;

    // One channel, sum wraps at 16 bits
    function automatic sample_t mix_channel(
        input sample_t      sprite,
        input sound_level_t level,
        input logic         spk
    );
        sample_t sound_term;
        sample_t spk_term;
        sound_term = sample_t'(level) << SOUND_SHIFT;
        spk_term   = sample_t'(spk) << SPEAKER_SHIFT;
        return sprite + sound_term + spk_term;
    endfunction

    // Speaker counts when forced on or switched on
    assign speaker_on_w = speaker_i & (SPEAKER_ENABLE | speaker_sw_i);

    assign mix_w.left  = mix_channel(sprite_audio_i, sound_left_i, speaker_on_w);
    assign mix_w.right = mix_channel(sprite_audio_i, sound_right_i, speaker_on_w);

    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            audio_o <= '0;
        end else begin
            audio_o <= mix_w;
        end
    end

endmodule

`default_nettype wire

// ==== logic/card_bus_arbiter.sv ====
// Picks which slot card drives the Apple data bus and merges the card interrupts
`timescale 1ns/1ps
`default_nettype none

module card_bus_arbiter
    import a2_card_pkg::*;
#(
    parameter bit BUS_DATA_OUT_ENABLE = 1'b1,
    parameter bit IRQ_OUT_ENABLE      = 1'b1
) (
    input  logic       clk_logic_w,
    input  logic       rst_n_i,
    input  card_resp_t card_resp_i [NUM_CARDS],
    input  bus_data_t  bus_data_i,
    output bus_drive_t bus_drive_o
);

    bus_data_t sel_data_w;
    logic      any_rd_w;
    logic      irq_all_n_w;
    logic      irq_out_n_w;

    // Walk from the lowest priority card up so index 0 wins
    always_comb begin
        sel_data_w = bus_data_i;
        for (int i = NUM_CARDS - 1; i >= 0; i--) begin
            if (card_resp_i[i].rd_en) begin
                sel_data_w = card_resp_i[i].data;
            end
        end
    end

    // Wired-OR style merge of the read enables and interrupts
    always_comb begin
        any_rd_w    = 1'b0;
        irq_all_n_w = 1'b1;
        for (int i = 0; i < NUM_CARDS; i++) begin
            any_rd_w    = any_rd_w | card_resp_i[i].rd_en;
            irq_all_n_w = irq_all_n_w & card_resp_i[i].irq_n;
        end
    end

    // Interrupt line stays released when IRQ output is off
    assign irq_out_n_w = IRQ_OUT_ENABLE ? irq_all_n_w : 1'b1;

    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus_drive_o.oe    <= 1'b0;
            bus_drive_o.irq_n <= 1'b1;
            bus_drive_o.data  <= '0;
        end else begin
            bus_drive_o.oe    <= any_rd_w & BUS_DATA_OUT_ENABLE;
            bus_drive_o.irq_n <= irq_out_n_w;
            bus_drive_o.data  <= sel_data_w;
        end
    end

endmodule

`default_nettype wire

// ==== logic/scanline_dimmer.sv ====
// Halves pixel color intensity on odd lines to imitate CRT scanlines
`timescale 1ns/1ps
`default_nettype none

module scanline_dimmer
    import a2_card_pkg::*;
#(
    parameter bit SCANLINES_ENABLE = 1'b0
) (
    input  logic       clk_logic_w,
    input  logic       rst_n_i,
    input  rgb_pixel_t pixel_i,
    input  logic       line_odd_i,
    input  logic       scanline_sw_i,
    output rgb_pixel_t pixel_o
);

    logic       dim_w;
    rgb_pixel_t pixel_w;

    // Half intensity is a plain right shift
    function automatic logic [7:0] halve(input logic [7:0] c);
        return {1'b0, c[7:1]};
    endfunction

    assign dim_w = line_odd_i & (SCANLINES_ENABLE | scanline_sw_i);

    always_comb begin
        pixel_w = pixel_i;
        if (dim_w) begin
            pixel_w.r = halve(pixel_i.r);
            pixel_w.g = halve(pixel_i.g);
            pixel_w.b = halve(pixel_i.b);
        end
    end

    // Active bit rides along unchanged
    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pixel_o <= '0;
        end else begin
            pixel_o <= pixel_w;
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_a2_card_core.sv ====
// Table-driven testbench that drives the card glue top level row by row and checks each result
`timescale 1ns/1ps
`default_nettype none

module tb_a2_card_core
    import a2_card_pkg::*;
;

    localparam int TBL_LEN     = 24;
    localparam int CYCLE_LIMIT = 2 * TBL_LEN + 100;

    // One row of stimulus without the card responses
    typedef struct packed {
        bus_data_t    bus_data;
        sample_t      sprite;
        sound_level_t left;
        sound_level_t right;
        logic         speaker;
        rgb_pixel_t   pixel;
        logic         line_odd;
        logic [1:0]   dip_n;
    } stim_row_t;

    logic         clk_logic_w = 1'b0;
    logic         rst_n_i;
    logic         a2_phi1_i;
    logic         a2_7m_i;
    logic         a2_reset_n_i;
    card_resp_t   card_resp [NUM_CARDS];
    bus_data_t    bus_data;
    sample_t      sprite_audio;
    sound_level_t sound_left;
    sound_level_t sound_right;
    logic         speaker;
    rgb_pixel_t   pixel_in;
    logic         line_odd;
    logic [1:0]   dip_switches_n;

    logic         phase_o;
    logic         clk_2m_stb_o;
    logic         clk_14m_stb_o;
    logic         system_reset_n_o;
    bus_drive_t   bus_drive_o;
    stereo_t      audio_o;
    rgb_pixel_t   pixel_o;

    stim_row_t    stim_tbl [TBL_LEN];
    card_resp_t   resp_tbl [TBL_LEN][NUM_CARDS];
    logic [31:0]  lcg_state = 32'hcfc4;
    int           cycle_cnt = 0;

    a2_card_core uut (
        .clk_logic_w      (clk_logic_w),
        .rst_n_i          (rst_n_i),
        .a2_phi1_i        (a2_phi1_i),
        .a2_7m_i          (a2_7m_i),
        .a2_reset_n_i     (a2_reset_n_i),
        .card_resp_i      (card_resp),
        .bus_data_i       (bus_data),
        .sprite_audio_i   (sprite_audio),
        .sound_left_i     (sound_left),
        .sound_right_i    (sound_right),
        .speaker_i        (speaker),
        .pixel_i          (pixel_in),
        .line_odd_i       (line_odd),
        .dip_switches_n_i (dip_switches_n),
        .phase_o          (phase_o),
        .clk_2m_stb_o     (clk_2m_stb_o),
        .clk_14m_stb_o    (clk_14m_stb_o),
        .system_reset_n_o (system_reset_n_o),
        .bus_drive_o      (bus_drive_o),
        .audio_o          (audio_o),
        .pixel_o          (pixel_o)
    );

    always #5 clk_logic_w = ~clk_logic_w;

    // Run limit scaled to the table length
    always @(posedge clk_logic_w) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $fatal(1, "Simulation stopped by timeout");
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_on_error();
        $display("Errors found");
        $fatal(1, "Stopping at first mismatch");
    endtask

    task automatic check_drive(input bus_drive_t got, input bus_drive_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s drive oe=%b irq=%b d=%h, expected oe=%b irq=%b d=%h",
                     $time, what, got.oe, got.irq_n, got.data, exp.oe, exp.irq_n, exp.data);
            stop_on_error();
        end
    endtask

    task automatic check_audio(input stereo_t got, input stereo_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s audio L=%h R=%h, expected L=%h R=%h",
                     $time, what, got.left, got.right, exp.left, exp.right);
            stop_on_error();
        end
    endtask

    task automatic check_pixel(input rgb_pixel_t got, input rgb_pixel_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s pixel %h, expected %h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    // Lowest index reader wins and interrupts are wire-ANDed
    function automatic bus_drive_t expect_drive(input int k);
        bus_drive_t e;
        logic       found;
        e.oe    = 1'b0;
        e.irq_n = 1'b1;
        e.data  = stim_tbl[k].bus_data;
        found   = 1'b0;
        for (int i = 0; i < NUM_CARDS; i++) begin
            if (resp_tbl[k][i].rd_en && !found) begin
                e.data = resp_tbl[k][i].data;
                found  = 1'b1;
            end
            if (resp_tbl[k][i].rd_en) begin
                e.oe = 1'b1;
            end
            if (!resp_tbl[k][i].irq_n) begin
                e.irq_n = 1'b0;
            end
        end
        return e;
    endfunction

    function automatic sample_t expect_channel(input sample_t sprite, input sound_level_t level,
                                               input logic spk_on);
        logic [31:0] sum;
        sum = sprite + (level << SOUND_SHIFT) + (spk_on ? (32'd1 << SPEAKER_SHIFT) : 32'd0);
        return sum[15:0];
    endfunction

    function automatic rgb_pixel_t expect_pixel(input stim_row_t row);
        rgb_pixel_t e;
        e = row.pixel;
        if (row.line_odd && !row.dip_n[0]) begin
            e.r = row.pixel.r >> 1;
            e.g = row.pixel.g >> 1;
            e.b = row.pixel.b >> 1;
        end
        return e;
    endfunction

    task automatic fill_table();
        for (int k = 0; k < TBL_LEN; k++) begin
            for (int i = 0; i < NUM_CARDS; i++) begin
                lcg_state = lcg_next(lcg_state);
                resp_tbl[k][i].data  = lcg_state[23:16];
                resp_tbl[k][i].irq_n = lcg_state[30] | lcg_state[29];
                // Rows cycle through none, several, all and random readers
                case (k % 4)
                    0:       resp_tbl[k][i].rd_en = 1'b0;
                    1:       resp_tbl[k][i].rd_en = (i != CARD_SERIAL);
                    2:       resp_tbl[k][i].rd_en = 1'b1;
                    default: resp_tbl[k][i].rd_en = lcg_state[31];
                endcase
                if (k % 6 == 0) begin
                    resp_tbl[k][i].irq_n = 1'b1;
                end
            end
            lcg_state = lcg_next(lcg_state);
            stim_tbl[k].bus_data = lcg_state[31:24];
            stim_tbl[k].sprite   = lcg_state[23:8];
            lcg_state = lcg_next(lcg_state);
            stim_tbl[k].left     = lcg_state[31:22];
            stim_tbl[k].right    = lcg_state[21:12];
            stim_tbl[k].speaker  = lcg_state[11] | ~k[3];
            lcg_state = lcg_next(lcg_state);
            stim_tbl[k].pixel    = lcg_state[31:7];
            stim_tbl[k].line_odd = k[2];
            stim_tbl[k].dip_n    = k[1:0];
        end
    endtask

    task automatic apply_row(input int k);
        for (int i = 0; i < NUM_CARDS; i++) begin
            card_resp[i] = resp_tbl[k][i];
        end
        bus_data       = stim_tbl[k].bus_data;
        sprite_audio   = stim_tbl[k].sprite;
        sound_left     = stim_tbl[k].left;
        sound_right    = stim_tbl[k].right;
        speaker        = stim_tbl[k].speaker;
        pixel_in       = stim_tbl[k].pixel;
        line_odd       = stim_tbl[k].line_odd;
        dip_switches_n = stim_tbl[k].dip_n;
    endtask

    task automatic check_row(input int k);
        stereo_t ea;
        logic    spk_on;
        string   tag;
        tag      = $sformatf("row %0d", k);
        spk_on   = stim_tbl[k].speaker & ~stim_tbl[k].dip_n[1];
        ea.left  = expect_channel(stim_tbl[k].sprite, stim_tbl[k].left, spk_on);
        ea.right = expect_channel(stim_tbl[k].sprite, stim_tbl[k].right, spk_on);
        check_drive(bus_drive_o, expect_drive(k), tag);
        check_audio(audio_o, ea, tag);
        check_pixel(pixel_o, expect_pixel(stim_tbl[k]), tag);
        check_bit(clk_2m_stb_o, 1'b0, {tag, " 2 MHz strobe"});
    endtask

    // Starts on a falling edge and returns three falling edges later
    task automatic toggle_clock_input(input bit is_phi1, input logic val);
        if (is_phi1) begin
            a2_phi1_i = val;
        end else begin
            a2_7m_i = val;
        end
        @(negedge clk_logic_w);
        check_bit(is_phi1 ? clk_2m_stb_o : clk_14m_stb_o, 1'b0, "strobe one cycle after edge");
        if (is_phi1) check_bit(phase_o, ~val, "phase one cycle after edge");
        @(negedge clk_logic_w);
        check_bit(is_phi1 ? clk_2m_stb_o : clk_14m_stb_o, 1'b1, "strobe two cycles after edge");
        if (is_phi1) check_bit(phase_o, val, "phase two cycles after edge");
        @(negedge clk_logic_w);
        check_bit(is_phi1 ? clk_2m_stb_o : clk_14m_stb_o, 1'b0, "strobe three cycles after edge");
    endtask

    initial begin
        bus_drive_t idle_drive;
        rst_n_i        = 1'b0;
        a2_phi1_i      = 1'b0;
        a2_7m_i        = 1'b0;
        a2_reset_n_i   = 1'b0;
        bus_data       = '0;
        sprite_audio   = '0;
        sound_left     = '0;
        sound_right    = '0;
        speaker        = 1'b0;
        pixel_in       = '0;
        line_odd       = 1'b0;
        dip_switches_n = 2'b11;
        for (int i = 0; i < NUM_CARDS; i++) begin
            card_resp[i].rd_en = 1'b0;
            card_resp[i].irq_n = 1'b1;
            card_resp[i].data  = 8'h00;
        end
        fill_table();

        repeat (2) @(posedge clk_logic_w);
        @(negedge clk_logic_w);
        rst_n_i = 1'b1;

        // Reset values
        idle_drive.oe    = 1'b0;
        idle_drive.irq_n = 1'b1;
        idle_drive.data  = 8'h00;
        check_drive(bus_drive_o, idle_drive, "after reset");
        check_audio(audio_o, '0, "after reset");
        check_pixel(pixel_o, '0, "after reset");
        check_bit(clk_2m_stb_o, 1'b0, "2 MHz strobe after reset");
        check_bit(clk_14m_stb_o, 1'b0, "14 MHz strobe after reset");
        check_bit(system_reset_n_o, 1'b0, "system reset after reset");

        for (int k = 0; k <= TBL_LEN; k++) begin
            if (k > 0) check_row(k - 1);
            if (k < TBL_LEN) apply_row(k);
            @(negedge clk_logic_w);
        end

        toggle_clock_input(1'b1, 1'b1);
        toggle_clock_input(1'b1, 1'b0);
        toggle_clock_input(1'b0, 1'b1);
        toggle_clock_input(1'b0, 1'b0);

        // Apple reset release takes two cycles to show
        a2_reset_n_i = 1'b1;
        @(negedge clk_logic_w);
        check_bit(system_reset_n_o, 1'b0, "system reset one cycle after release");
        @(negedge clk_logic_w);
        check_bit(system_reset_n_o, 1'b1, "system reset two cycles after release");

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
